// File: bubbleEmu.f
logic/bubblePkg.sv
logic/timingIf.sv
logic/bufWriteIf.sv
logic/cfgRegs.sv
logic/timingGenerator.sv
logic/spiLoader.sv
logic/bubbleInterface.sv
logic/bubbleEmuTop.sv
verification/spiFlashModel.sv
verification/bubbleEmuTb.sv

// File: logic/bubbleEmuTop.sv
`timescale 1ns/10ps

module bubbleEmuTop #(
    parameter int pageBytes = 4,
    parameter int imageBytes = 16
) (
    // 48 MHz system clock
    input  logic MCLK,
    input  logic rst,

    // host configuration writes
    input  logic cfgWr,
    input  logic cfgAddr,
    input  logic [7:0] cfgData,

    // bubble control
    input  logic nBSEN,
    input  logic nREPEN,
    input  logic nBOOTEN,

    // 4 MHz clock and data to the host
    output logic CLKOUT,
    output logic DOUT0,
    output logic DOUT1,
    output logic dataGate,

    // SPI NOR flash
    output logic nROMCS,
    output logic ROMMOSI,
    input  logic ROMMISO,
    output logic ROMCLK
);

    logic [bubblePkg::imageBits-1:0] imageNum;
    logic [bubblePkg::posBits-1:0] pageCount;
    logic bootSel;

    timingIf #(.pageBytes(pageBytes)) timBus ();
    bufWriteIf #(.pageBytes(pageBytes)) bwBus ();

    cfgRegs cfgRegs0 (
        .MCLK      (MCLK),
        .rst       (rst),
        .cfgWr     (cfgWr),
        .cfgAddr   (cfgAddr),
        .cfgData   (cfgData),
        .imageNum  (imageNum),
        .pageCount (pageCount)
    );

    timingGenerator #(.pageBytes(pageBytes)) timingGenerator0 (
        .MCLK      (MCLK),
        .rst       (rst),
        .nBSEN     (nBSEN),
        .nREPEN    (nREPEN),
        .nBOOTEN   (nBOOTEN),
        .pageCount (pageCount),
        .CLKOUT    (CLKOUT),
        .bootSel   (bootSel),
        .tim       (timBus.gen),
        .req       (bwBus.requester)
    );

    spiLoader #(.pageBytes(pageBytes), .imageBytes(imageBytes)) spiLoader0 (
        .MCLK      (MCLK),
        .rst       (rst),
        .imageNum  (imageNum),
        .bootSel   (bootSel),
        .tim       (timBus.user),
        .bw        (bwBus.loader),
        .nCS       (nROMCS),
        .MOSI      (ROMMOSI),
        .CLK       (ROMCLK),
        .MISO      (ROMMISO)
    );

    bubbleInterface #(.pageBytes(pageBytes)) bubbleInterface0 (
        .MCLK      (MCLK),
        .rst       (rst),
        .tim       (timBus.user),
        .bw        (bwBus.buffer),
        .DOUT0     (DOUT0),
        .DOUT1     (DOUT1),
        .dataGate  (dataGate)
    );

endmodule

// File: logic/bubbleInterface.sv
`timescale 1ns/10ps

module bubbleInterface #(
    parameter int pageBytes = 4
) (
    input  logic MCLK,
    input  logic rst,
    timingIf.user tim,
    bufWriteIf.buffer bw,
    output logic DOUT0,
    output logic DOUT1,
    output logic dataGate
);

    localparam int idxBits = $clog2(pageBytes * 4);

    logic [7:0] pageBuf [pageBytes];
    logic [7:0] curByte;
    logic [7:0] aligned;

    always_ff @(posedge MCLK) begin
        if (bw.wrEn) begin
            pageBuf[bw.wrAddr] <= bw.wrData;
        end
    end

    // four pairs per byte, MSB first
    assign curByte = pageBuf[tim.outIndex[idxBits-1:2]];
    assign aligned = curByte << {tim.outIndex[1:0], 1'b0};

    always_ff @(posedge MCLK) begin
        if (rst) begin
            DOUT0 <= 1'b0;
            DOUT1 <= 1'b0;
            dataGate <= 1'b0;
        end else if (tim.bitTick) begin
            if (tim.phase == bubblePkg::accOutput) begin
                DOUT0 <= aligned[7];
                DOUT1 <= aligned[6];
                dataGate <= 1'b1;
            end else begin
                // last pair held one full period, then released
                DOUT0 <= 1'b0;
                DOUT1 <= 1'b0;
                dataGate <= 1'b0;
            end
        end
    end

    // loader must be done before the page goes out
    noWriteOut: assert property (@(posedge MCLK) disable iff (rst)
        bw.wrEn |-> tim.phase != bubblePkg::accOutput);

endmodule

// File: logic/bubblePkg.sv
package bubblePkg;

    // access phase seen by the loader and the bubble interface
    typedef enum logic [1:0] {
        accIdle   = 2'd0,
        accLoad   = 2'd1,
        accOutput = 2'd2
    } accType_t;

    // MCLK cycles per output clock, 48 MHz down to 4 MHz
    localparam int clkDiv = 12;

    // plain SPI read, no dummy byte
    localparam logic [7:0] flashReadCmd = 8'h03;

    localparam int imageBits = 3;
    localparam int posBits = 8;

endpackage

// File: logic/bufWriteIf.sv
`timescale 1ns/10ps

interface bufWriteIf #(
    parameter int pageBytes = 4
);

    // page load request, held until accepted
    logic loadValid;
    logic loadReady;

    // byte writes into the page buffer
    logic wrEn;
    logic [$clog2(pageBytes)-1:0] wrAddr;
    logic [7:0] wrData;
    logic pageDone;

    modport requester (output loadValid, input loadReady, input pageDone);
    modport loader (input loadValid, output loadReady, output wrEn, output wrAddr,
                    output wrData, output pageDone);
    modport buffer (input wrEn, input wrAddr, input wrData);

endinterface

// File: logic/cfgRegs.sv
`timescale 1ns/10ps

module cfgRegs (
    input  logic MCLK,
    input  logic rst,
    input  logic cfgWr,
    input  logic cfgAddr,
    input  logic [7:0] cfgData,
    output logic [bubblePkg::imageBits-1:0] imageNum,
    output logic [bubblePkg::posBits-1:0] pageCount
);

    // address 0 image number, address 1 page count
    always_ff @(posedge MCLK) begin
        if (rst) begin
            imageNum <= '0;
            pageCount <= bubblePkg::posBits'(4);
        end else if (cfgWr) begin
            if (cfgAddr) begin
                pageCount <= bubblePkg::posBits'(cfgData);
            end else begin
                imageNum <= cfgData[bubblePkg::imageBits-1:0];
            end
        end
    end

    // a zero page count would stall the position wrap
    pageCountNonZero: assert property (@(posedge MCLK) disable iff (rst)
        cfgWr && cfgAddr |=> pageCount != '0);

    // upper bits of an image write would be lost
    imageFits: assert property (@(posedge MCLK) disable iff (rst)
        cfgWr && !cfgAddr |=> 8'(imageNum) == $past(cfgData));

endmodule

// File: logic/spiLoader.sv
`timescale 1ns/10ps

module spiLoader #(
    parameter int pageBytes = 4,
    parameter int imageBytes = 16
) (
    input  logic MCLK,
    input  logic rst,
    input  logic [bubblePkg::imageBits-1:0] imageNum,
    input  logic bootSel,
    timingIf.user tim,
    bufWriteIf.loader bw,
    output logic nCS,
    output logic MOSI,
    output logic CLK,
    input  logic MISO
);

    localparam int byteBits = $clog2(pageBytes);

    typedef enum logic [1:0] {
        stIdle,
        stSend,
        stRead,
        stFinish
    } loadState_t;

    loadState_t state;
    logic [1:0] sub;
    logic [4:0] bitCnt;
    logic [byteBits-1:0] byteCnt;
    logic [31:0] txShift;
    logic [7:0] rxShift;
    logic [23:0] flashAddr;
    logic [bubblePkg::imageBits-1:0] image;

    // boot image is always image 0
    assign image = bootSel ? '0 : imageNum;
    assign flashAddr = 24'(image) * 24'(imageBytes) + 24'(tim.absPos) * 24'(pageBytes);

    assign bw.loadReady = (state == stIdle);
    assign MOSI = txShift[31];

    // four MCLK per SCK bit, mode 0
    always_ff @(posedge MCLK) begin
        if (rst) begin
            state <= stIdle;
            nCS <= 1'b1;
            CLK <= 1'b0;
            sub <= '0;
            bitCnt <= '0;
            byteCnt <= '0;
            txShift <= '0;
            bw.wrEn <= 1'b0;
            bw.pageDone <= 1'b0;
        end else begin
            bw.wrEn <= 1'b0;
            bw.pageDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (bw.loadValid) begin
                        txShift <= {bubblePkg::flashReadCmd, flashAddr};
                        nCS <= 1'b0;
                        sub <= '0;
                        bitCnt <= '0;
                        byteCnt <= '0;
                        state <= stSend;
                    end
                end
                stSend, stRead: begin
                    sub <= sub + 1'b1;
                    // SCK high in the second half of the bit
                    CLK <= (sub == 2'd1) || (sub == 2'd2);
                    if (sub == 2'd3) begin
                        // counter wraps to 0 after the 32 command bits
                        bitCnt <= bitCnt + 1'b1;
                        if (state == stSend) begin
                            txShift <= txShift << 1;
                            if (bitCnt == 5'd31) begin
                                state <= stRead;
                            end
                        end else if (bitCnt[2:0] == 3'd7) begin
                            bw.wrEn <= 1'b1;
                            byteCnt <= byteCnt + 1'b1;
                            if (byteCnt == byteBits'(pageBytes - 1)) begin
                                state <= stFinish;
                            end
                        end
                    end
                end
                stFinish: begin
                    nCS <= 1'b1;
                    bw.pageDone <= 1'b1;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    // sample just before the falling edge
    always_ff @(posedge MCLK) begin
        if (state == stRead && sub == 2'd3) begin
            rxShift <= {rxShift[6:0], MISO};
            bw.wrAddr <= byteCnt;
            bw.wrData <= {rxShift[6:0], MISO};
        end
    end

    // flash only selected while a page is in flight
    csIdle: assert property (@(posedge MCLK) disable iff (rst)
        tim.phase == bubblePkg::accIdle |-> nCS);

endmodule

// File: logic/timingGenerator.sv
`timescale 1ns/10ps

module timingGenerator #(
    parameter int pageBytes = 4
) (
    input  logic MCLK,
    input  logic rst,
    input  logic nBSEN,
    input  logic nREPEN,
    input  logic nBOOTEN,
    input  logic [bubblePkg::posBits-1:0] pageCount,
    output logic CLKOUT,
    output logic bootSel,
    timingIf.gen tim,
    bufWriteIf.requester req
);

    localparam int pairCount = pageBytes * 4;
    localparam int idxBits = $clog2(pairCount);
    localparam int halfDiv = bubblePkg::clkDiv / 2;

    logic [$clog2(bubblePkg::clkDiv)-1:0] divCnt;

    // CLKOUT low for the first half period, tick with the rise
    always_ff @(posedge MCLK) begin
        if (rst) begin
            divCnt <= '0;
            CLKOUT <= 1'b0;
            tim.bitTick <= 1'b0;
        end else begin
            divCnt <= (divCnt == bubblePkg::clkDiv - 1) ? '0 : divCnt + 1'b1;
            CLKOUT <= (divCnt >= halfDiv - 1) && (divCnt != bubblePkg::clkDiv - 1);
            tim.bitTick <= (divCnt == halfDiv - 1);
        end
    end

    always_ff @(posedge MCLK) begin
        if (rst) begin
            tim.phase <= bubblePkg::accIdle;
            tim.absPos <= '0;
            tim.outIndex <= '0;
            bootSel <= 1'b0;
            req.loadValid <= 1'b0;
        end else begin
            case (tim.phase)
                bubblePkg::accIdle: begin
                    // enable while idle always starts over at page 0
                    if (!nBSEN) begin
                        tim.absPos <= '0;
                        bootSel <= !nBOOTEN;
                        req.loadValid <= 1'b1;
                        tim.phase <= bubblePkg::accLoad;
                    end
                end
                bubblePkg::accLoad: begin
                    if (req.loadReady) begin
                        req.loadValid <= 1'b0;
                    end
                    if (req.pageDone) begin
                        tim.phase <= bubblePkg::accOutput;
                    end
                end
                bubblePkg::accOutput: begin
                    if (tim.bitTick) begin
                        // index wraps back to 0 after the last pair
                        tim.outIndex <= tim.outIndex + 1'b1;
                        if (tim.outIndex == idxBits'(pairCount - 1)) begin
                            if (nBSEN) begin
                                tim.phase <= bubblePkg::accIdle;
                            end else begin
                                if (nREPEN) begin
                                    tim.absPos <= (tim.absPos == pageCount - 1'b1) ?
                                                  '0 : tim.absPos + 1'b1;
                                end
                                req.loadValid <= 1'b1;
                                tim.phase <= bubblePkg::accLoad;
                            end
                        end
                    end
                end
                default: tim.phase <= bubblePkg::accIdle;
            endcase
        end
    end

    // loader may only finish a page it has accepted
    pageAfterAccept: assert property (@(posedge MCLK) disable iff (rst)
        req.pageDone |-> tim.phase == bubblePkg::accLoad && !req.loadValid);

endmodule

// File: logic/timingIf.sv
`timescale 1ns/10ps

interface timingIf #(
    parameter int pageBytes = 4
);

    bubblePkg::accType_t phase;
    logic [bubblePkg::posBits-1:0] absPos;
    // one MCLK pulse per CLKOUT period, on the rising edge
    logic bitTick;
    // bit pair within the page
    logic [$clog2(pageBytes * 4)-1:0] outIndex;

    modport gen (output phase, output absPos, output bitTick, output outIndex);
    modport user (input phase, input absPos, input bitTick, input outIndex);

endinterface

// File: verification/bubbleEmuTb.sv
`timescale 1ns/10ps

module bubbleEmuTb;

    localparam int pageBytes = 4;
    localparam int imageBytes = 16;
    localparam int pairCount = pageBytes * 4;
    localparam int recWords = 8;
    localparam int flashBytes = 64;
    localparam logic [7:0] readCmd = 8'h03;

    logic MCLK;
    logic rst;
    logic cfgWr;
    logic cfgAddr;
    logic [7:0] cfgData;
    logic nBSEN;
    logic nREPEN;
    logic nBOOTEN;
    logic CLKOUT;
    logic DOUT0;
    logic DOUT1;
    logic dataGate;
    logic nROMCS;
    logic ROMMOSI;
    logic ROMMISO;
    logic ROMCLK;

    // four records of two words, then the flash bytes
    logic [15:0] testData [0:recWords+flashBytes-1];
    int cycleCount = 0;
    int cycleLimit = 0;

    bubbleEmuTop #(.pageBytes(pageBytes), .imageBytes(imageBytes)) i_dut (.*);

    spiFlashModel flash (
        .nCS  (nROMCS),
        .CLK  (ROMCLK),
        .MOSI (ROMMOSI),
        .MISO (ROMMISO)
    );

    always #10 MCLK = ~MCLK;

    always @(posedge MCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("run did not finish within %0d MCLK cycles", cycleLimit);
            abortRun();
        end
    end

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %0h actual %0h", testName, expected, actual);
            abortRun();
        end
    endtask

    task automatic writeCfg(input logic addr, input logic [7:0] data);
        @(negedge MCLK);
        cfgWr = 1'b1;
        cfgAddr = addr;
        cfgData = data;
        @(negedge MCLK);
        cfgWr = 1'b0;
    endtask

    // pair k is page bits 2k and 2k+1, MSB first from byte 0
    function automatic logic [1:0] expectedPair(input int image, input int pos, input int k);
        int addr;
        logic [7:0] b;
        addr = image * imageBytes + pos * pageBytes + k / 4;
        b = testData[recWords + addr][7:0];
        return {b[7 - 2 * (k % 4)], b[6 - 2 * (k % 4)]};
    endfunction

    // quiet output, flash deselected, CLKOUT half period of 6
    task automatic checkIdle(input string name, input int cycles);
        int sinceEdge;
        bit seenEdge;
        logic lastClk;
        sinceEdge = 0;
        seenEdge = 0;
        @(negedge MCLK);
        lastClk = CLKOUT;
        repeat (cycles) begin
            @(negedge MCLK);
            sinceEdge++;
            checkValue({name, " dataGate"}, 0, dataGate);
            checkValue({name, " nROMCS"}, 1, nROMCS);
            checkValue({name, " ROMCLK"}, 0, ROMCLK);
            if (CLKOUT !== lastClk) begin
                if (seenEdge) begin
                    checkValue({name, " CLKOUT half period"}, 6, sinceEdge);
                end
                seenEdge = 1;
                sinceEdge = 0;
                lastClk = CLKOUT;
            end
        end
    endtask

    task automatic runTest(input int idx);
        string name;
        logic [15:0] ctrl;
        int image;
        int pageCount;
        int pages;
        int useImage;
        int pos;
        bit repeatOn;
        bit bootOn;
        name = $sformatf("test%0d", idx + 1);
        image = testData[2 * idx];
        ctrl = testData[2 * idx + 1];
        pageCount = ctrl[7:0];
        pages = ctrl[11:8];
        repeatOn = ctrl[12];
        bootOn = ctrl[13];
        useImage = bootOn ? 0 : image;
        writeCfg(1'b0, 8'(image));
        writeCfg(1'b1, 8'(pageCount));
        @(negedge MCLK);
        nREPEN = !repeatOn;
        nBOOTEN = !bootOn;
        nBSEN = 1'b0;
        pos = 0;
        for (int p = 0; p < pages; p++) begin
            // wait out the page load
            do begin
                @(negedge CLKOUT);
            end while (dataGate !== 1'b1);
            for (int k = 0; k < pairCount; k++) begin
                if (k > 0) begin
                    @(negedge CLKOUT);
                    checkValue($sformatf("%s page %0d gate %0d", name, p, k), 1, dataGate);
                end
                checkValue($sformatf("%s page %0d pair %0d", name, p, k),
                           expectedPair(useImage, pos, k), {DOUT0, DOUT1});
                // last page is out, let it finish and stop
                if (p == pages - 1 && k == 0) begin
                    @(negedge MCLK);
                    nBSEN = 1'b1;
                end
            end
            @(negedge CLKOUT);
            checkValue($sformatf("%s page %0d gate after end", name, p), 0, dataGate);
            if (!repeatOn) begin
                pos = (pos + 1) % pageCount;
            end
        end
        // longer than a load, so an extra page would show up
        checkIdle(name, 300 + int'($urandom % 64));
        checkValue({name, " read command"}, readCmd, flash.lastCmd);
        nREPEN = 1'b1;
        nBOOTEN = 1'b1;
    endtask

    initial begin
        int seed;
        MCLK = 1'b0;
        rst = 1'b1;
        cfgWr = 1'b0;
        cfgAddr = 1'b0;
        cfgData = 8'h00;
        nBSEN = 1'b1;
        nREPEN = 1'b1;
        nBOOTEN = 1'b1;
        seed = $urandom(32'h642f);
        $readmemh("verification/bubbleTestdata.hex", testData);
        if ($isunknown(testData[0]) || $isunknown(testData[recWords + flashBytes - 1])) begin
            $display("test data file could not be read completely");
            abortRun();
        end
        // space past the images gets an address-dependent fill
        for (int i = 0; i < 256; i++) begin
            flash.mem[i] = (i < flashBytes) ? testData[recWords + i][7:0] : 8'(i * 37 + 11);
        end
        // per page: load budget plus the output time
        for (int r = 0; r < recWords / 2; r++) begin
            cycleLimit += int'(testData[2 * r + 1][11:8]) *
                          (300 + pairCount * bubblePkg::clkDiv);
        end
        cycleLimit = cycleLimit * 4;
        repeat (5) @(negedge MCLK);
        rst = 1'b0;
        @(negedge MCLK);
        checkValue("reset CLKOUT", 0, CLKOUT);
        checkValue("reset DOUT", 0, {DOUT0, DOUT1});
        checkIdle("reset idle", 100);
        for (int r = 0; r < recWords / 2; r++) begin
            repeat (int'($urandom % 16)) @(negedge MCLK);
            runTest(r);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verification/bubbleTestdata.hex
// records: image number, then {flags, pages to read, page count}; flags 1 repeat, 2 boot
// then 64 flash bytes, 16 per image, 4 pages of 4 bytes each
0001 0104
0002 0503
0003 1304
0003 2302
5a 96 e7 18 81 7e c3 3c
24 db 66 99 0f f0 a5 c6
3c a5 0f f0 12 34 56 78
9a bc de f1 e1 d2 c3 b4
71 8e 29 d6 4b b4 93 6c
05 fa 37 c8 e4 1b 7d 82
11 22 44 88 ee dd bb 77
69 96 c5 3a 0d b0 f3 cf

// File: verification/spiFlashModel.sv
`timescale 1ns/10ps

module spiFlashModel (
    input  logic nCS,
    input  logic CLK,
    input  logic MOSI,
    output logic MISO
);

    // byte array, filled by the testbench
    logic [7:0] mem [0:255];
    logic [7:0] lastCmd;

    logic [31:0] cmdShift;
    logic [23:0] addr;
    int rxBits;
    int txBits;

    initial begin
        MISO = 1'b0;
        lastCmd = 8'h00;
        rxBits = 0;
        txBits = 0;
    end

    // every select starts a new transfer
    always @(negedge nCS) begin
        rxBits = 0;
        txBits = 0;
    end

    // command byte and 24-bit address, MSB first
    always @(posedge CLK) begin
        if (!nCS && rxBits < 32) begin
            cmdShift = {cmdShift[30:0], MOSI};
            rxBits = rxBits + 1;
            if (rxBits == 32) begin
                lastCmd = cmdShift[31:24];
                addr = cmdShift[23:0];
            end
        end
    end

    // data out on the falling edge, next byte after eight bits
    always @(negedge CLK) begin
        if (!nCS && rxBits == 32) begin
            MISO <= mem[addr[7:0]][7 - txBits];
            txBits = txBits + 1;
            if (txBits == 8) begin
                txBits = 0;
                addr = addr + 1'b1;
            end
        end
    end

endmodule
